/* files.f */
rtl/rewrite_mgr_pkg.sv
rtl/rx_payload_buf.sv
rtl/rewrite_req_fetch.sv
rtl/rewrite_table_update.sv
rtl/rewrite_mgr_top.sv
dv/tb_rewrite_mgr.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rewrite manager testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_rewrite_mgr -f files.f -o tb_rewrite_mgr > build.log 2>&1 \
    && ./obj_dir/tb_rewrite_mgr > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "Regression passed" sim.log \
    && echo "Simulation status: PASS" \
    || { echo "Simulation status: FAIL"; exit 1; }

/* dv/tb_rewrite_mgr.sv */
`timescale 1ns/100ps

module tb_rewrite_mgr;

    localparam int NUM_REQ       = 8;
    localparam int WRAP_IDX      = 3;               // This request sits at byte 4088
    localparam int NOTIF_TIMEOUT = 200;             // Long enough to ride out update back-pressure
    localparam int DRAIN_TIMEOUT = 2000;

    typedef struct packed {
        rewrite_mgr_pkg::flow_id_t      flowid;
        rewrite_mgr_pkg::ip_addr_t      their_ip;
        rewrite_mgr_pkg::ip_addr_t      rewrite_addr;
        rewrite_mgr_pkg::payload_ptr_t  head_ptr;
    } exp_entry_t;

    logic                           clk;
    logic                           rst;
    logic                           notif_cyc, notif_stb, notif_we, notif_ack;
    rewrite_mgr_pkg::flow_id_t      notif_flowid;
    rewrite_mgr_pkg::payload_ptr_t  notif_head_ptr;
    logic                           pbuf_cyc, pbuf_stb, pbuf_we, pbuf_ack;
    rewrite_mgr_pkg::buf_adr_t      pbuf_adr;
    rewrite_mgr_pkg::buf_word_t     pbuf_dat_w;
    logic                           rx_tbl_cyc, rx_tbl_stb, rx_tbl_we, rx_tbl_ack;
    rewrite_mgr_pkg::ip_addr_t      rx_tbl_key, rx_tbl_val;
    logic                           tx_tbl_cyc, tx_tbl_stb, tx_tbl_we, tx_tbl_ack;
    rewrite_mgr_pkg::ip_addr_t      tx_tbl_key, tx_tbl_val;
    logic                           ptr_cyc, ptr_stb, ptr_we, ptr_ack;
    rewrite_mgr_pkg::flow_id_t      ptr_flowid;
    rewrite_mgr_pkg::payload_ptr_t  ptr_head_ptr;

    logic [2:0]                     slave_stb;      // Bit 0 RX table, bit 1 TX table, bit 2 TCP engine
    logic [2:0]                     slave_ack;

    integer                         seed = 50485;
    int                             errors = 0;
    int                             timeouts = 0;
    int                             notified = 0;
    int                             ptr_count = 0;
    exp_entry_t                     sb_q[$];        // Outstanding requests in notification order
    logic                           sb_valid = 1'b0;
    rewrite_mgr_pkg::flow_id_t      exp_flowid;
    rewrite_mgr_pkg::ip_addr_t      exp_their_ip;
    rewrite_mgr_pkg::ip_addr_t      exp_rewrite_addr;
    rewrite_mgr_pkg::payload_ptr_t  exp_next_ptr;
    rewrite_mgr_pkg::payload_ptr_t  req_ptr [NUM_REQ];
    rewrite_mgr_pkg::ip_addr_t      req_their_ip [NUM_REQ];
    rewrite_mgr_pkg::ip_addr_t      req_rewrite_addr [NUM_REQ];
    bit                             used [rewrite_mgr_pkg::BUF_WORDS];

    assign slave_stb  = {ptr_stb, tx_tbl_stb, rx_tbl_stb};
    assign rx_tbl_ack = slave_ack[0];
    assign tx_tbl_ack = slave_ack[1];
    assign ptr_ack    = slave_ack[2];

    rewrite_mgr_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        errors++;
        $display("FAILED %s expected %h got %h", name, expected, actual);
    endtask

    task automatic report_event(input string what);
        errors++;
        $display("Check error: %s", what);
    endtask

    // ========================================
    // Checks
    // ========================================
    reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !(notif_ack || rx_tbl_cyc || tx_tbl_cyc || ptr_cyc))
        else report_value("notif_ack/rx_tbl_cyc/tx_tbl_cyc/ptr_cyc", 32'h0,
            {28'h0, $sampled(notif_ack), $sampled(rx_tbl_cyc), $sampled(tx_tbl_cyc),
             $sampled(ptr_cyc)});
    rx_key_ok: assert property (@(posedge clk) disable iff (rst)
        rx_tbl_ack |-> rx_tbl_key == exp_their_ip)
        else report_value("rx_tbl_key", $sampled(exp_their_ip), $sampled(rx_tbl_key));
    rx_val_ok: assert property (@(posedge clk) disable iff (rst)
        rx_tbl_ack |-> rx_tbl_val == exp_rewrite_addr)
        else report_value("rx_tbl_val", $sampled(exp_rewrite_addr), $sampled(rx_tbl_val));
    tx_key_ok: assert property (@(posedge clk) disable iff (rst)
        tx_tbl_ack |-> tx_tbl_key == exp_rewrite_addr)    // Swapped pair
        else report_value("tx_tbl_key", $sampled(exp_rewrite_addr), $sampled(tx_tbl_key));
    tx_val_ok: assert property (@(posedge clk) disable iff (rst)
        tx_tbl_ack |-> tx_tbl_val == exp_their_ip)
        else report_value("tx_tbl_val", $sampled(exp_their_ip), $sampled(tx_tbl_val));
    ptr_flow_ok: assert property (@(posedge clk) disable iff (rst)
        ptr_ack |-> ptr_flowid == exp_flowid)
        else report_value("ptr_flowid", 32'($sampled(exp_flowid)),
            32'($sampled(ptr_flowid)));
    ptr_head_ok: assert property (@(posedge clk) disable iff (rst)
        ptr_ack |-> ptr_head_ptr == exp_next_ptr)
        else report_value("ptr_head_ptr", 32'($sampled(exp_next_ptr)),
            32'($sampled(ptr_head_ptr)));
    stb_exclusive: assert property (@(posedge clk) disable iff (rst) $onehot0(slave_stb))
        else report_event("more than one table or pointer strobe was high");
    stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
        (slave_stb & ~{ptr_cyc, tx_tbl_cyc, rx_tbl_cyc}) == 3'b000)
        else report_event("a table or pointer strobe was high without its cyc");
    stb_is_write: assert property (@(posedge clk) disable iff (rst)
        (slave_stb & ~{ptr_we, tx_tbl_we, rx_tbl_we}) == 3'b000)
        else report_event("a table or pointer strobe was high without its write enable");
    stb_held: assert property (@(posedge clk) disable iff (rst)
        ($past(slave_stb & ~slave_ack) & ~slave_stb) == 3'b000)
        else report_event("a table or pointer strobe dropped before its ack");
    rx_then_tx: assert property (@(posedge clk) disable iff (rst) rx_tbl_ack |=> tx_tbl_stb)
        else report_event("the TX table write did not follow the RX table write");
    tx_then_ptr: assert property (@(posedge clk) disable iff (rst) tx_tbl_ack |=> ptr_stb)
        else report_event("the pointer write did not follow the TX table write");
    tx_after_rx: assert property (@(posedge clk) disable iff (rst)
        $rose(tx_tbl_stb) |-> $past(rx_tbl_ack))
        else report_event("a TX table write started without a finished RX write");
    ptr_after_tx: assert property (@(posedge clk) disable iff (rst)
        $rose(ptr_stb) |-> $past(tx_tbl_ack))
        else report_event("a pointer write started without a finished TX write");
    write_expected: assert property (@(posedge clk) disable iff (rst)
        (|slave_stb) |-> sb_valid)
        else report_event("a table or pointer write came with no request outstanding");

    // ========================================
    // Scoreboard and device models
    // ========================================
    task automatic refresh_head();
        sb_valid = (sb_q.size() > 0);
        if (sb_valid) begin
            exp_flowid       = sb_q[0].flowid;
            exp_their_ip     = sb_q[0].their_ip;
            exp_rewrite_addr = sb_q[0].rewrite_addr;
            exp_next_ptr     = rewrite_mgr_pkg::payload_ptr_t'(
                (int'(sb_q[0].head_ptr) + rewrite_mgr_pkg::REQ_BYTES) % 4096); // 4088 wraps to 0
        end
    endtask

    always @(posedge clk) begin
        if (!rst && ptr_ack) begin
            if (sb_q.size() > 0) begin
                sb_q.delete(0);                     // Oldest request retired
            end
            ptr_count++;
            refresh_head();
        end
    end

    task automatic serve_slave(input int idx);
        int delay;
        forever begin
            @(posedge clk);
            #10;
            if (slave_stb[idx]) begin
                delay = {$random(seed)} % 6;        // 0 to 5 cycles
                repeat (delay) begin
                    @(posedge clk);
                    #10;
                end
                slave_ack[idx] = 1'b1;
                @(posedge clk);
                #10;
                slave_ack[idx] = 1'b0;
            end
        end
    endtask

    // ========================================
    // Stimulus
    // ========================================
    task automatic write_word(input rewrite_mgr_pkg::buf_adr_t adr,
                              input rewrite_mgr_pkg::buf_word_t data);
        int cycles;
        pbuf_cyc   = 1'b1;
        pbuf_stb   = 1'b1;
        pbuf_we    = 1'b1;
        pbuf_adr   = adr;
        pbuf_dat_w = data;
        cycles     = 0;
        do begin
            @(posedge clk);
            #10;
            cycles++;
        end while (!pbuf_ack && cycles < 10);
        if (!pbuf_ack) begin
            timeouts++;
            $display("Timeout: payload buffer write to word %0d was not acknowledged", adr);
        end
        pbuf_cyc = 1'b0;
        pbuf_stb = 1'b0;
        pbuf_we  = 1'b0;
    endtask

    task automatic load_requests();
        int word;
        int tries;
        used[1022] = 1'b1;
        used[1023] = 1'b1;
        for (int i = 0; i < NUM_REQ; i++) begin
            if (i == WRAP_IDX) begin
                word = 1022;
            end else begin
                tries = 0;
                do begin
                    word = {$random(seed)} % 1022;
                    tries++;
                end while ((used[word] || used[word + 1]) && tries < 1000);
                used[word]     = 1'b1;
                used[word + 1] = 1'b1;
            end
            req_ptr[i]          = rewrite_mgr_pkg::payload_ptr_t'(word * 4);
            req_their_ip[i]     = $random(seed);
            req_rewrite_addr[i] = $random(seed);
            write_word(rewrite_mgr_pkg::buf_adr_t'(word), req_their_ip[i]);
            write_word(rewrite_mgr_pkg::buf_adr_t'(word + 1), req_rewrite_addr[i]);
        end
    endtask

    task automatic send_notif(input int idx);
        int         cycles;
        exp_entry_t ent;
        notif_flowid   = rewrite_mgr_pkg::flow_id_t'($random(seed));
        notif_head_ptr = req_ptr[idx];
        notif_cyc      = 1'b1;
        notif_stb      = 1'b1;
        notif_we       = 1'b1;
        cycles         = 0;
        do begin
            @(posedge clk);
            #10;
            cycles++;
        end while (!notif_ack && cycles < NOTIF_TIMEOUT);
        if (notif_ack) begin
            ent.flowid       = notif_flowid;
            ent.their_ip     = req_their_ip[idx];
            ent.rewrite_addr = req_rewrite_addr[idx];
            ent.head_ptr     = req_ptr[idx];
            sb_q.push_back(ent);
            refresh_head();
            notified++;
        end else begin
            timeouts++;
            $display("Timeout: notification %0d was never acknowledged", idx);
        end
        notif_cyc = 1'b0;
        notif_stb = 1'b0;
        notif_we  = 1'b0;
    endtask

    initial begin
        int cycles;
        rst            = 1'b1;
        notif_cyc      = 1'b0;
        notif_stb      = 1'b0;
        notif_we       = 1'b0;
        notif_flowid   = '0;
        notif_head_ptr = '0;
        pbuf_cyc       = 1'b0;
        pbuf_stb       = 1'b0;
        pbuf_we        = 1'b0;
        pbuf_adr       = '0;
        pbuf_dat_w     = '0;
        slave_ack      = 3'b000;
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
        fork
            serve_slave(0);
            serve_slave(1);
            serve_slave(2);
        join_none
        load_requests();
        for (int i = 0; i < NUM_REQ; i++) begin
            send_notif(i);                          // Back to back, so requests overlap
        end
        cycles = 0;
        while (ptr_count < NUM_REQ && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        if (ptr_count < NUM_REQ) begin
            timeouts++;
            $display("Timeout: only %0d of %0d pointer advances were acknowledged",
                     ptr_count, NUM_REQ);
        end
        $display("Summary: %0d check errors, %0d timeouts, %0d notifications, %0d pointer writes",
                 errors, timeouts, notified, ptr_count);
        if (errors == 0 && timeouts == 0 && notified == NUM_REQ && ptr_count == NUM_REQ) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* rtl/rewrite_mgr_top.sv */
`timescale 1ns/100ps

module rewrite_mgr_top (
     input  logic                           clk
    ,input  logic                           rst

    ,input  logic                           notif_cyc
    ,input  logic                           notif_stb
    ,input  logic                           notif_we
    ,input  rewrite_mgr_pkg::flow_id_t      notif_flowid
    ,input  rewrite_mgr_pkg::payload_ptr_t  notif_head_ptr
    ,output logic                           notif_ack

    ,input  logic                           pbuf_cyc
    ,input  logic                           pbuf_stb
    ,input  logic                           pbuf_we
    ,input  rewrite_mgr_pkg::buf_adr_t      pbuf_adr
    ,input  rewrite_mgr_pkg::buf_word_t     pbuf_dat_w
    ,output logic                           pbuf_ack

    ,output logic                           rx_tbl_cyc
    ,output logic                           rx_tbl_stb
    ,output logic                           rx_tbl_we
    ,output rewrite_mgr_pkg::ip_addr_t      rx_tbl_key
    ,output rewrite_mgr_pkg::ip_addr_t      rx_tbl_val
    ,input  logic                           rx_tbl_ack

    ,output logic                           tx_tbl_cyc
    ,output logic                           tx_tbl_stb
    ,output logic                           tx_tbl_we
    ,output rewrite_mgr_pkg::ip_addr_t      tx_tbl_key
    ,output rewrite_mgr_pkg::ip_addr_t      tx_tbl_val
    ,input  logic                           tx_tbl_ack

    ,output logic                           ptr_cyc
    ,output logic                           ptr_stb
    ,output logic                           ptr_we
    ,output rewrite_mgr_pkg::flow_id_t      ptr_flowid
    ,output rewrite_mgr_pkg::payload_ptr_t  ptr_head_ptr
    ,input  logic                           ptr_ack
);

    // Fetch to buffer
    logic                           rd_cyc;
    logic                           rd_stb;
    rewrite_mgr_pkg::buf_adr_t      rd_adr;
    rewrite_mgr_pkg::buf_word_t     rd_dat;
    logic                           rd_ack;

    // Fetch to update
    logic                           req_cyc;
    logic                           req_stb;
    rewrite_mgr_pkg::flow_id_t      req_flowid;
    rewrite_mgr_pkg::payload_ptr_t  req_head_ptr;
    rewrite_mgr_pkg::ip_addr_t      req_their_ip;
    rewrite_mgr_pkg::ip_addr_t      req_rewrite_addr;
    logic                           req_ack;

    rewrite_req_fetch u_fetch (
         .clk               (clk)
        ,.rst               (rst)
        ,.notif_cyc         (notif_cyc)
        ,.notif_stb         (notif_stb)
        ,.notif_we          (notif_we)
        ,.notif_flowid      (notif_flowid)
        ,.notif_head_ptr    (notif_head_ptr)
        ,.notif_ack         (notif_ack)
        ,.rd_cyc            (rd_cyc)
        ,.rd_stb            (rd_stb)
        ,.rd_adr            (rd_adr)
        ,.rd_dat            (rd_dat)
        ,.rd_ack            (rd_ack)
        ,.req_cyc           (req_cyc)
        ,.req_stb           (req_stb)
        ,.req_flowid        (req_flowid)
        ,.req_head_ptr      (req_head_ptr)
        ,.req_their_ip      (req_their_ip)
        ,.req_rewrite_addr  (req_rewrite_addr)
        ,.req_ack           (req_ack)
    );

    rx_payload_buf u_buf (
         .clk               (clk)
        ,.rst               (rst)
        ,.pbuf_cyc          (pbuf_cyc)
        ,.pbuf_stb          (pbuf_stb)
        ,.pbuf_we           (pbuf_we)
        ,.pbuf_adr          (pbuf_adr)
        ,.pbuf_dat_w        (pbuf_dat_w)
        ,.pbuf_ack          (pbuf_ack)
        ,.rd_cyc            (rd_cyc)
        ,.rd_stb            (rd_stb)
        ,.rd_adr            (rd_adr)
        ,.rd_dat            (rd_dat)
        ,.rd_ack            (rd_ack)
    );

    rewrite_table_update u_update (
         .clk               (clk)
        ,.rst               (rst)
        ,.req_cyc           (req_cyc)
        ,.req_stb           (req_stb)
        ,.req_flowid        (req_flowid)
        ,.req_head_ptr      (req_head_ptr)
        ,.req_their_ip      (req_their_ip)
        ,.req_rewrite_addr  (req_rewrite_addr)
        ,.req_ack           (req_ack)
        ,.rx_tbl_cyc        (rx_tbl_cyc)
        ,.rx_tbl_stb        (rx_tbl_stb)
        ,.rx_tbl_we         (rx_tbl_we)
        ,.rx_tbl_key        (rx_tbl_key)
        ,.rx_tbl_val        (rx_tbl_val)
        ,.rx_tbl_ack        (rx_tbl_ack)
        ,.tx_tbl_cyc        (tx_tbl_cyc)
        ,.tx_tbl_stb        (tx_tbl_stb)
        ,.tx_tbl_we         (tx_tbl_we)
        ,.tx_tbl_key        (tx_tbl_key)
        ,.tx_tbl_val        (tx_tbl_val)
        ,.tx_tbl_ack        (tx_tbl_ack)
        ,.ptr_cyc           (ptr_cyc)
        ,.ptr_stb           (ptr_stb)
        ,.ptr_we            (ptr_we)
        ,.ptr_flowid        (ptr_flowid)
        ,.ptr_head_ptr      (ptr_head_ptr)
        ,.ptr_ack           (ptr_ack)
    );

endmodule

/* rtl/rewrite_table_update.sv */
`timescale 1ns/100ps

module rewrite_table_update (
     input  logic                           clk
    ,input  logic                           rst

    // Request slave from the fetch block
    ,input  logic                           req_cyc
    ,input  logic                           req_stb
    ,input  rewrite_mgr_pkg::flow_id_t      req_flowid
    ,input  rewrite_mgr_pkg::payload_ptr_t  req_head_ptr
    ,input  rewrite_mgr_pkg::ip_addr_t      req_their_ip
    ,input  rewrite_mgr_pkg::ip_addr_t      req_rewrite_addr
    ,output logic                           req_ack

    // RX rewrite table master
    ,output logic                           rx_tbl_cyc
    ,output logic                           rx_tbl_stb
    ,output logic                           rx_tbl_we
    ,output rewrite_mgr_pkg::ip_addr_t      rx_tbl_key
    ,output rewrite_mgr_pkg::ip_addr_t      rx_tbl_val
    ,input  logic                           rx_tbl_ack

    // TX rewrite table master
    ,output logic                           tx_tbl_cyc
    ,output logic                           tx_tbl_stb
    ,output logic                           tx_tbl_we
    ,output rewrite_mgr_pkg::ip_addr_t      tx_tbl_key
    ,output rewrite_mgr_pkg::ip_addr_t      tx_tbl_val
    ,input  logic                           tx_tbl_ack

    // TCP receive pointer master
    ,output logic                           ptr_cyc
    ,output logic                           ptr_stb
    ,output logic                           ptr_we
    ,output rewrite_mgr_pkg::flow_id_t      ptr_flowid
    ,output rewrite_mgr_pkg::payload_ptr_t  ptr_head_ptr
    ,input  logic                           ptr_ack
);

    rewrite_mgr_pkg::update_state_t state;
    rewrite_mgr_pkg::flow_id_t      flowid_r;
    rewrite_mgr_pkg::payload_ptr_t  head_ptr_r;
    rewrite_mgr_pkg::ip_addr_t      their_ip_r;
    rewrite_mgr_pkg::ip_addr_t      rewrite_addr_r;
    logic                           req_in;

    assign req_in = req_cyc && req_stb && !req_ack;

    // ========================================
    // Control
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= rewrite_mgr_pkg::UPD_IDLE;
            req_ack <= 1'b0;
        end else begin
            req_ack <= 1'b0;
            case (state)
                rewrite_mgr_pkg::UPD_IDLE: begin
                    if (req_in) begin
                        req_ack <= 1'b1;
                        state   <= rewrite_mgr_pkg::UPD_RX_WR;
                    end
                end
                rewrite_mgr_pkg::UPD_RX_WR: begin
                    if (rx_tbl_ack) begin
                        state <= rewrite_mgr_pkg::UPD_TX_WR;
                    end
                end
                rewrite_mgr_pkg::UPD_TX_WR: begin
                    if (tx_tbl_ack) begin
                        state <= rewrite_mgr_pkg::UPD_PTR_WR;
                    end
                end
                rewrite_mgr_pkg::UPD_PTR_WR: begin
                    if (ptr_ack) begin
                        state <= rewrite_mgr_pkg::UPD_IDLE;
                    end
                end
                default: begin
                    state <= rewrite_mgr_pkg::UPD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rewrite_mgr_pkg::UPD_IDLE && req_in) begin
            flowid_r       <= req_flowid;
            head_ptr_r     <= req_head_ptr;
            their_ip_r     <= req_their_ip;
            rewrite_addr_r <= req_rewrite_addr;
        end
    end

    // ========================================
    // Table and pointer writes
    // ========================================
    assign rx_tbl_cyc = (state == rewrite_mgr_pkg::UPD_RX_WR);
    assign rx_tbl_stb = (state == rewrite_mgr_pkg::UPD_RX_WR);
    assign rx_tbl_we  = (state == rewrite_mgr_pkg::UPD_RX_WR);
    assign rx_tbl_key = their_ip_r;
    assign rx_tbl_val = rewrite_addr_r;

    // TX path sees the old address, so the pair is swapped
    assign tx_tbl_cyc = (state == rewrite_mgr_pkg::UPD_TX_WR);
    assign tx_tbl_stb = (state == rewrite_mgr_pkg::UPD_TX_WR);
    assign tx_tbl_we  = (state == rewrite_mgr_pkg::UPD_TX_WR);
    assign tx_tbl_key = rewrite_addr_r;
    assign tx_tbl_val = their_ip_r;

    assign ptr_cyc      = (state == rewrite_mgr_pkg::UPD_PTR_WR);
    assign ptr_stb      = (state == rewrite_mgr_pkg::UPD_PTR_WR);
    assign ptr_we       = (state == rewrite_mgr_pkg::UPD_PTR_WR);
    assign ptr_flowid   = flowid_r;
    assign ptr_head_ptr = head_ptr_r                // Skip past the request
                        + rewrite_mgr_pkg::payload_ptr_t'(rewrite_mgr_pkg::REQ_BYTES);

    // The three writes of one request never overlap
    one_master_stb: assert property (
        @(posedge clk) disable iff (rst) $onehot0({rx_tbl_stb, tx_tbl_stb, ptr_stb}));

endmodule

/* rtl/rewrite_req_fetch.sv */
`timescale 1ns/100ps

module rewrite_req_fetch (
     input  logic                           clk
    ,input  logic                           rst

    // Notification slave
    ,input  logic                           notif_cyc
    ,input  logic                           notif_stb
    ,input  logic                           notif_we
    ,input  rewrite_mgr_pkg::flow_id_t      notif_flowid
    ,input  rewrite_mgr_pkg::payload_ptr_t  notif_head_ptr
    ,output logic                           notif_ack

    // Payload buffer read master
    ,output logic                           rd_cyc
    ,output logic                           rd_stb
    ,output rewrite_mgr_pkg::buf_adr_t      rd_adr
    ,input  rewrite_mgr_pkg::buf_word_t     rd_dat
    ,input  logic                           rd_ack

    // Request master towards the update block
    ,output logic                           req_cyc
    ,output logic                           req_stb
    ,output rewrite_mgr_pkg::flow_id_t      req_flowid
    ,output rewrite_mgr_pkg::payload_ptr_t  req_head_ptr
    ,output rewrite_mgr_pkg::ip_addr_t      req_their_ip
    ,output rewrite_mgr_pkg::ip_addr_t      req_rewrite_addr
    ,input  logic                           req_ack
);

    rewrite_mgr_pkg::fetch_state_t  state;
    rewrite_mgr_pkg::flow_id_t      flowid_r;
    rewrite_mgr_pkg::payload_ptr_t  head_ptr_r;
    rewrite_mgr_pkg::payload_ptr_t  word1_ptr;
    rewrite_mgr_pkg::ip_addr_t      their_ip_r;
    rewrite_mgr_pkg::ip_addr_t      rewrite_addr_r;
    logic                           rd_stb_r;
    logic                           notif_req;

    assign notif_req = notif_cyc && notif_stb && notif_we && !notif_ack;

    // Second request word, wraps with the byte pointer
    assign word1_ptr = head_ptr_r
                     + rewrite_mgr_pkg::payload_ptr_t'(rewrite_mgr_pkg::WORD_BYTES);

    // ========================================
    // Control
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= rewrite_mgr_pkg::FETCH_IDLE;
            notif_ack <= 1'b0;
            rd_stb_r  <= 1'b0;
        end else begin
            notif_ack <= 1'b0;
            case (state)
                rewrite_mgr_pkg::FETCH_IDLE: begin
                    if (notif_req) begin
                        notif_ack <= 1'b1;
                        rd_stb_r  <= 1'b1;
                        state     <= rewrite_mgr_pkg::FETCH_RD0;
                    end
                end
                rewrite_mgr_pkg::FETCH_RD0: begin
                    if (rd_ack) begin
                        rd_stb_r <= 1'b0;               // Drop stb after ack
                        state    <= rewrite_mgr_pkg::FETCH_RD1;
                    end
                end
                rewrite_mgr_pkg::FETCH_RD1: begin
                    if (rd_ack) begin
                        rd_stb_r <= 1'b0;
                        state    <= rewrite_mgr_pkg::FETCH_PUSH;
                    end else if (!rd_stb_r) begin
                        rd_stb_r <= 1'b1;               // Start second read
                    end
                end
                rewrite_mgr_pkg::FETCH_PUSH: begin
                    if (req_ack) begin
                        state <= rewrite_mgr_pkg::FETCH_IDLE;
                    end
                end
                default: begin
                    state <= rewrite_mgr_pkg::FETCH_IDLE;
                end
            endcase
        end
    end

    // ========================================
    // Request registers
    // ========================================
    always_ff @(posedge clk) begin
        if (state == rewrite_mgr_pkg::FETCH_IDLE && notif_req) begin
            flowid_r   <= notif_flowid;
            head_ptr_r <= notif_head_ptr;
        end
        if (state == rewrite_mgr_pkg::FETCH_RD0 && rd_ack) begin
            their_ip_r <= rd_dat;
        end
        if (state == rewrite_mgr_pkg::FETCH_RD1 && rd_ack) begin
            rewrite_addr_r <= rd_dat;
        end
    end

    assign rd_cyc = rd_stb_r;
    assign rd_stb = rd_stb_r;
    assign rd_adr = (state == rewrite_mgr_pkg::FETCH_RD1) ? word1_ptr[11:2]
                                                          : head_ptr_r[11:2];

    assign req_cyc          = (state == rewrite_mgr_pkg::FETCH_PUSH);
    assign req_stb          = (state == rewrite_mgr_pkg::FETCH_PUSH);
    assign req_flowid       = flowid_r;
    assign req_head_ptr     = head_ptr_r;
    assign req_their_ip     = their_ip_r;
    assign req_rewrite_addr = rewrite_addr_r;

    // Back-pressure from the update block holds the request
    req_stb_held: assert property (
        @(posedge clk) disable iff (rst) (req_stb && !req_ack) |=> req_stb);

endmodule

/* rtl/rx_payload_buf.sv */
`timescale 1ns/100ps

module rx_payload_buf (
     input  logic                           clk
    ,input  logic                           rst

    // External write port
    ,input  logic                           pbuf_cyc
    ,input  logic                           pbuf_stb
    ,input  logic                           pbuf_we
    ,input  rewrite_mgr_pkg::buf_adr_t      pbuf_adr
    ,input  rewrite_mgr_pkg::buf_word_t     pbuf_dat_w
    ,output logic                           pbuf_ack

    // Internal read port
    ,input  logic                           rd_cyc
    ,input  logic                           rd_stb
    ,input  rewrite_mgr_pkg::buf_adr_t      rd_adr
    ,output rewrite_mgr_pkg::buf_word_t     rd_dat
    ,output logic                           rd_ack
);

    rewrite_mgr_pkg::buf_word_t mem [rewrite_mgr_pkg::BUF_WORDS];

    logic wr_req;
    logic rd_req;

    // A new cycle is only seen while no ack is out
    assign wr_req = pbuf_cyc && pbuf_stb && !pbuf_ack;
    assign rd_req = rd_cyc && rd_stb && !rd_ack;

    always_ff @(posedge clk) begin
        if (wr_req && pbuf_we) begin
            mem[pbuf_adr] <= pbuf_dat_w;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            rd_dat <= mem[rd_adr];                      // Old word on a same-cycle collision
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pbuf_ack <= 1'b0;
            rd_ack   <= 1'b0;
        end else begin
            pbuf_ack <= wr_req;
            rd_ack   <= rd_req;
        end
    end

    // ========================================
    // Bus protocol checks
    // ========================================
    pbuf_stb_in_cyc: assert property (
        @(posedge clk) disable iff (rst) pbuf_stb |-> pbuf_cyc);

    rd_stb_in_cyc: assert property (
        @(posedge clk) disable iff (rst) rd_stb |-> rd_cyc);

    pbuf_ack_single: assert property (
        @(posedge clk) disable iff (rst) pbuf_ack |=> !pbuf_ack);

    rd_ack_single: assert property (
        @(posedge clk) disable iff (rst) rd_ack |=> !rd_ack);

endmodule

/* rtl/rewrite_mgr_pkg.sv */
package rewrite_mgr_pkg;

    // ========================================
    // Sizes
    // ========================================
    localparam int BUF_WORDS  = 1024;                   // Payload buffer depth in words
    localparam int BUF_ADR_W  = $clog2(BUF_WORDS);
    localparam int WORD_BYTES = 4;                      // Bytes per payload buffer word
    localparam int REQ_BYTES  = 8;                      // Peer IP word, then rewrite address word

    // ========================================
    // Types
    // ========================================
    typedef logic [7:0]           flow_id_t;
    typedef logic [11:0]          payload_ptr_t;        // Byte pointer, wraps at 4096
    typedef logic [31:0]          ip_addr_t;
    typedef logic [31:0]          buf_word_t;
    typedef logic [BUF_ADR_W-1:0] buf_adr_t;            // Word index into the payload buffer

    // Request fetch FSM
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_RD0,                                      // Reading the peer IP word
        FETCH_RD1,                                      // Reading the rewrite address word
        FETCH_PUSH
    } fetch_state_t;

    // Table update FSM
    typedef enum logic [1:0] {
        UPD_IDLE,
        UPD_RX_WR,
        UPD_TX_WR,
        UPD_PTR_WR
    } update_state_t;

endpackage
